// ==== logic/mips_pkg.sv ====
`default_nettype none

package mips_pkg;

	// ##################################################
	// basic data types.
	// ##################################################

	typedef logic [31:0] word_t;
	typedef logic [4:0] reg_idx_t;

	// register format, used by all SPECIAL opcodes.
	typedef struct packed {
		logic [5:0] opcode;
		reg_idx_t rs;
		reg_idx_t rt;
		reg_idx_t rd;
		logic [4:0] shamt;
		logic [5:0] funct;
	} r_fields_t;

	// immediate format, used by loads and stores.
	typedef struct packed {
		logic [5:0] opcode;
		reg_idx_t rs;
		reg_idx_t rt;
		logic [15:0] imm;
	} i_fields_t;

	// the decoder looks at the same word through both formats.
	typedef union packed {
		r_fields_t r;
		i_fields_t i;
	} instr_t;

	typedef enum logic [3:0] {
		ALU_SLL  = 4'd0,
		ALU_SRL  = 4'd1,
		ALU_SRA  = 4'd2,
		ALU_ADD  = 4'd3,
		ALU_ADDU = 4'd4,
		ALU_SUB  = 4'd5,
		ALU_SUBU = 4'd6,
		ALU_AND  = 4'd7,
		ALU_OR   = 4'd8,
		ALU_XOR  = 4'd9,
		ALU_NOR  = 4'd10,
		ALU_SLT  = 4'd11
	} alu_op_t;

	typedef enum logic [1:0] {
		MEM_BYTE = 2'd0,
		MEM_HALF = 2'd1,
		MEM_WORD = 2'd2
	} mem_width_t;

	// request bundle towards the byte-banked data memory.
	typedef struct packed {
		logic en;
		logic we;
		logic [3:0] bank_select; // bit 3 is the byte at offset 0.
		logic [9:0] addr; // word address.
		word_t di;
	} mem_req_t;

	// ##################################################
	// opcodes and function codes.
	// ##################################################

	localparam logic [5:0] OPCODE_SPECIAL = 6'h00;
	localparam logic [5:0] OP_LB  = 6'h20;
	localparam logic [5:0] OP_LH  = 6'h21;
	localparam logic [5:0] OP_LW  = 6'h23;
	localparam logic [5:0] OP_LBU = 6'h24;
	localparam logic [5:0] OP_LHU = 6'h25;
	localparam logic [5:0] OP_SB  = 6'h28;
	localparam logic [5:0] OP_SH  = 6'h29;
	localparam logic [5:0] OP_SW  = 6'h2B;

	localparam logic [5:0] FUNCT_SLL  = 6'h00;
	localparam logic [5:0] FUNCT_SRL  = 6'h02;
	localparam logic [5:0] FUNCT_SRA  = 6'h03;
	localparam logic [5:0] FUNCT_ADD  = 6'h20;
	localparam logic [5:0] FUNCT_ADDU = 6'h21;
	localparam logic [5:0] FUNCT_SUB  = 6'h22;
	localparam logic [5:0] FUNCT_SUBU = 6'h23;
	localparam logic [5:0] FUNCT_AND  = 6'h24;
	localparam logic [5:0] FUNCT_OR   = 6'h25;
	localparam logic [5:0] FUNCT_XOR  = 6'h26;
	localparam logic [5:0] FUNCT_NOR  = 6'h27;
	localparam logic [5:0] FUNCT_SLT  = 6'h2A;

endpackage

`default_nettype wire

// ==== logic/alu.sv ====
`default_nettype none

module alu (
	input  mips_pkg::alu_op_t op,
	input  mips_pkg::word_t s_value,
	input  mips_pkg::word_t t_value,
	input  logic [4:0] shamt,
	output mips_pkg::word_t result
);

	mips_pkg::word_t sum;
	mips_pkg::word_t diff;
	logic less;

	assign sum = s_value + t_value; // wraps, overflow is not trapped.
	assign diff = s_value - t_value;
	assign less = $signed(s_value) < $signed(t_value);

	always_comb
	begin
		case (op)
			mips_pkg::ALU_SLL:  result = t_value << shamt;
			mips_pkg::ALU_SRL:  result = t_value >> shamt;
			mips_pkg::ALU_SRA:  result = $signed(t_value) >>> shamt;
			mips_pkg::ALU_ADD,
			mips_pkg::ALU_ADDU: result = sum;
			mips_pkg::ALU_SUB,
			mips_pkg::ALU_SUBU: result = diff;
			mips_pkg::ALU_AND:  result = s_value & t_value;
			mips_pkg::ALU_OR:   result = s_value | t_value;
			mips_pkg::ALU_XOR:  result = s_value ^ t_value;
			mips_pkg::ALU_NOR:  result = ~(s_value | t_value);
			mips_pkg::ALU_SLT:  result = {31'd0, less};
			default:            result = '0;
		endcase
	end

endmodule

`default_nettype wire

// ==== logic/register_file.sv ====
`default_nettype none

module register_file (
	input  logic clk,
	input  logic reset,
	input  logic rd_en,
	input  mips_pkg::reg_idx_t rs_idx,
	input  mips_pkg::reg_idx_t rt_idx,
	input  logic we,
	input  mips_pkg::reg_idx_t wr_idx,
	input  mips_pkg::word_t wr_data,
	output mips_pkg::word_t s_value,
	output mips_pkg::word_t t_value
);

	// register 0 has no storage.
	mips_pkg::word_t regs [1:31];

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int i = 1; i < 32; i++)
				regs[i] <= '0;
		end
		else if (we && wr_idx != '0)
		begin
			regs[wr_idx] <= wr_data;
		end
	end

	// operands are sampled once per instruction and held.
	always_ff @(posedge clk)
	begin
		if (rd_en)
		begin
			s_value <= (rs_idx == '0) ? '0 : regs[rs_idx];
			t_value <= (rt_idx == '0) ? '0 : regs[rt_idx];
		end
	end

endmodule

`default_nettype wire

// ==== logic/load_store_unit.sv ====
`default_nettype none

module load_store_unit #(
	parameter int MEM_ADDR_WIDTH = 10
) (
	input  logic clk,
	input  logic reset,
	input  logic start,
	input  logic store,
	input  mips_pkg::mem_width_t width,
	input  logic signed_load,
	input  mips_pkg::word_t base,
	input  logic [15:0] offset,
	input  mips_pkg::word_t store_data,
	output mips_pkg::mem_req_t mem_req,
	input  mips_pkg::word_t mem_do,
	input  logic mem_do_ack,
	output logic done,
	output mips_pkg::word_t load_data
);

	mips_pkg::word_t eff_addr;
	logic [1:0] lane;
	logic [3:0] banks;
	mips_pkg::word_t lane_data;
	logic [MEM_ADDR_WIDTH-1:0] word_addr;

	logic [1:0] lane_q;
	mips_pkg::mem_width_t width_q;
	logic signed_q;
	mips_pkg::word_t shifted;

	// ##################################################
	// address and lane selection.
	// ##################################################

	assign eff_addr = base + {{16{offset[15]}}, offset};
	assign word_addr = eff_addr[MEM_ADDR_WIDTH+1:2];

	always_comb
	begin
		case (width)
			mips_pkg::MEM_BYTE:
			begin
				lane = eff_addr[1:0];
				banks = 4'b1000 >> lane;
				lane_data = {4{store_data[7:0]}}; // memory keeps only the enabled bank.
			end
			mips_pkg::MEM_HALF:
			begin
				lane = {eff_addr[1], 1'b0};
				banks = lane[1] ? 4'b0011 : 4'b1100;
				lane_data = {2{store_data[15:0]}};
			end
			default:
			begin
				lane = 2'b00;
				banks = 4'b1111;
				lane_data = store_data;
			end
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			mem_req <= '0;
			done <= 1'b0;
		end
		else
		begin
			done <= 1'b0;
			if (start)
			begin
				mem_req.en <= 1'b1;
				mem_req.we <= store;
				mem_req.bank_select <= banks;
				mem_req.addr <= word_addr;
				mem_req.di <= store ? lane_data : '0;
			end
			else if (mem_req.en && mem_do_ack)
			begin
				mem_req.en <= 1'b0;
				mem_req.we <= 1'b0;
				done <= 1'b1;
			end
		end
	end

	// ##################################################
	// load data extraction.
	// ##################################################

	// move the addressed lane up to bits 31 and below.
	assign shifted = mem_do << {lane_q, 3'b000};

	always_ff @(posedge clk)
	begin
		if (start)
		begin
			lane_q <= lane;
			width_q <= width;
			signed_q <= signed_load;
		end
		if (mem_req.en && mem_do_ack)
		begin
			case (width_q)
				mips_pkg::MEM_BYTE:
					load_data <= {{24{signed_q & shifted[31]}}, shifted[31:24]};
				mips_pkg::MEM_HALF:
					load_data <= {{16{signed_q & shifted[31]}}, shifted[31:16]};
				default:
					load_data <= mem_do;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== logic/decode_fsm.sv ====
`default_nettype none

module decode_fsm (
	input  logic clk,
	input  logic reset,
	input  logic data_in_ready,
	input  mips_pkg::word_t data_in,
	output logic ack_prev,
	output logic data_out_ready,
	output mips_pkg::word_t data_out,
	input  logic ack_next,
	output logic rf_rd_en,
	output mips_pkg::reg_idx_t rs_idx,
	output mips_pkg::reg_idx_t rt_idx,
	output logic rf_we,
	output mips_pkg::reg_idx_t rf_wr_idx,
	output mips_pkg::word_t rf_wr_data,
	output mips_pkg::alu_op_t alu_op,
	output logic [4:0] shamt,
	input  mips_pkg::word_t alu_result,
	input  mips_pkg::word_t rt_value,
	output logic mem_start,
	output logic mem_store,
	output mips_pkg::mem_width_t mem_width,
	output logic mem_signed,
	output logic [15:0] imm,
	input  logic mem_done,
	input  mips_pkg::word_t load_data
);

	typedef enum logic [2:0] {
		S_IDLE, S_READ, S_EXEC, S_MEM_WAIT, S_WRITE_BACK, S_WAIT_ACK
	} state_t;

	typedef enum logic [1:0] {
		K_RTYPE, K_LOAD, K_STORE, K_UNSUPPORTED
	} kind_t;

	state_t state;
	kind_t kind;
	mips_pkg::instr_t instr_q;
	mips_pkg::word_t result_q;

	// ##################################################
	// decode of the held instruction word.
	// ##################################################

	always_comb
	begin
		kind = K_UNSUPPORTED;
		alu_op = mips_pkg::ALU_ADD;
		mem_width = mips_pkg::MEM_WORD;
		mem_signed = 1'b0;
		if (instr_q.r.opcode == mips_pkg::OPCODE_SPECIAL)
		begin
			kind = K_RTYPE;
			case (instr_q.r.funct)
				mips_pkg::FUNCT_SLL:  alu_op = mips_pkg::ALU_SLL;
				mips_pkg::FUNCT_SRL:  alu_op = mips_pkg::ALU_SRL;
				mips_pkg::FUNCT_SRA:  alu_op = mips_pkg::ALU_SRA;
				mips_pkg::FUNCT_ADD:  alu_op = mips_pkg::ALU_ADD;
				mips_pkg::FUNCT_ADDU: alu_op = mips_pkg::ALU_ADDU;
				mips_pkg::FUNCT_SUB:  alu_op = mips_pkg::ALU_SUB;
				mips_pkg::FUNCT_SUBU: alu_op = mips_pkg::ALU_SUBU;
				mips_pkg::FUNCT_AND:  alu_op = mips_pkg::ALU_AND;
				mips_pkg::FUNCT_OR:   alu_op = mips_pkg::ALU_OR;
				mips_pkg::FUNCT_XOR:  alu_op = mips_pkg::ALU_XOR;
				mips_pkg::FUNCT_NOR:  alu_op = mips_pkg::ALU_NOR;
				mips_pkg::FUNCT_SLT:  alu_op = mips_pkg::ALU_SLT;
				default:              kind = K_UNSUPPORTED; // unknown funct.
			endcase
		end
		else
		begin
			case (instr_q.i.opcode)
				mips_pkg::OP_LW:  kind = K_LOAD;
				mips_pkg::OP_SW:  kind = K_STORE;
				mips_pkg::OP_LH, mips_pkg::OP_LHU, mips_pkg::OP_SH:
				begin
					kind = (instr_q.i.opcode == mips_pkg::OP_SH) ? K_STORE : K_LOAD;
					mem_width = mips_pkg::MEM_HALF;
				end
				mips_pkg::OP_LB, mips_pkg::OP_LBU, mips_pkg::OP_SB:
				begin
					kind = (instr_q.i.opcode == mips_pkg::OP_SB) ? K_STORE : K_LOAD;
					mem_width = mips_pkg::MEM_BYTE;
				end
				default: kind = K_UNSUPPORTED;
			endcase
			// only the plain lh and lb extend the sign.
			mem_signed = (instr_q.i.opcode == mips_pkg::OP_LH) ||
				(instr_q.i.opcode == mips_pkg::OP_LB);
		end
	end

	assign rs_idx = instr_q.r.rs;
	assign rt_idx = instr_q.r.rt;
	assign shamt = instr_q.r.shamt;
	assign imm = instr_q.i.imm;

	assign rf_rd_en = (state == S_READ);
	assign mem_start = (state == S_EXEC) && (kind == K_LOAD || kind == K_STORE);
	assign mem_store = (kind == K_STORE);

	// R-type results go to rd, load results go to rt.
	assign rf_we = (state == S_WRITE_BACK) && (kind == K_RTYPE || kind == K_LOAD);
	assign rf_wr_idx = (kind == K_RTYPE) ? instr_q.r.rd : instr_q.i.rt;
	assign rf_wr_data = result_q;

	assign data_out_ready = (state == S_WAIT_ACK);

	// ##################################################
	// sequencing and handshakes.
	// ##################################################

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= S_IDLE;
			ack_prev <= 1'b0;
			data_out <= '0;
		end
		else
		begin
			ack_prev <= 1'b0; // a single cycle pulse.
			case (state)
				S_IDLE:
				begin
					if (data_in_ready)
					begin
						ack_prev <= 1'b1;
						state <= S_READ;
					end
				end
				S_READ: state <= S_EXEC; // operands are latched here.
				S_EXEC:
				begin
					if (kind == K_LOAD || kind == K_STORE)
						state <= S_MEM_WAIT;
					else
						state <= S_WRITE_BACK;
				end
				S_MEM_WAIT:
				begin
					if (mem_done)
						state <= S_WRITE_BACK;
				end
				S_WRITE_BACK:
				begin
					data_out <= result_q;
					state <= S_WAIT_ACK;
				end
				S_WAIT_ACK:
				begin
					if (ack_next)
						state <= S_IDLE;
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (state == S_IDLE && data_in_ready)
			instr_q <= data_in;
		if (state == S_EXEC)
			result_q <= (kind == K_RTYPE) ? alu_result : '0; // unsupported gives zero.
		if (state == S_MEM_WAIT && mem_done)
			result_q <= (kind == K_LOAD) ? load_data : rt_value;
	end

endmodule

`default_nettype wire

// ==== logic/instruction_decoder.sv ====
`default_nettype none

module instruction_decoder #(
	parameter int MEM_ADDR_WIDTH = 10
) (
	input  logic clk,
	input  logic reset,
	input  logic data_in_ready,
	input  mips_pkg::word_t data_in,
	output logic ack_prev,
	output logic data_out_ready,
	output mips_pkg::word_t data_out,
	input  logic ack_next,
	output mips_pkg::mem_req_t mem_req,
	input  mips_pkg::word_t mem_do,
	input  logic mem_do_ack
);

	logic rf_rd_en;
	mips_pkg::reg_idx_t rs_idx;
	mips_pkg::reg_idx_t rt_idx;
	logic rf_we;
	mips_pkg::reg_idx_t rf_wr_idx;
	mips_pkg::word_t rf_wr_data;
	mips_pkg::word_t s_value;
	mips_pkg::word_t t_value;

	mips_pkg::alu_op_t alu_op;
	logic [4:0] shamt;
	mips_pkg::word_t alu_result;

	logic mem_start;
	logic mem_store;
	mips_pkg::mem_width_t mem_width;
	logic mem_signed;
	logic [15:0] imm;
	logic mem_done;
	mips_pkg::word_t load_data;

	decode_fsm u_fsm (
		.clk(clk),
		.reset(reset),
		.data_in_ready(data_in_ready),
		.data_in(data_in),
		.ack_prev(ack_prev),
		.data_out_ready(data_out_ready),
		.data_out(data_out),
		.ack_next(ack_next),
		.rf_rd_en(rf_rd_en),
		.rs_idx(rs_idx),
		.rt_idx(rt_idx),
		.rf_we(rf_we),
		.rf_wr_idx(rf_wr_idx),
		.rf_wr_data(rf_wr_data),
		.alu_op(alu_op),
		.shamt(shamt),
		.alu_result(alu_result),
		.rt_value(t_value),
		.mem_start(mem_start),
		.mem_store(mem_store),
		.mem_width(mem_width),
		.mem_signed(mem_signed),
		.imm(imm),
		.mem_done(mem_done),
		.load_data(load_data)
	);

	register_file u_regs (
		.clk(clk),
		.reset(reset),
		.rd_en(rf_rd_en),
		.rs_idx(rs_idx),
		.rt_idx(rt_idx),
		.we(rf_we),
		.wr_idx(rf_wr_idx),
		.wr_data(rf_wr_data),
		.s_value(s_value),
		.t_value(t_value)
	);

	alu u_alu (
		.op(alu_op),
		.s_value(s_value),
		.t_value(t_value),
		.shamt(shamt),
		.result(alu_result)
	);

	// the base comes from rs and the store data from rt.
	load_store_unit #(
		.MEM_ADDR_WIDTH(MEM_ADDR_WIDTH)
	) u_lsu (
		.clk(clk),
		.reset(reset),
		.start(mem_start),
		.store(mem_store),
		.width(mem_width),
		.signed_load(mem_signed),
		.base(s_value),
		.offset(imm),
		.store_data(t_value),
		.mem_req(mem_req),
		.mem_do(mem_do),
		.mem_do_ack(mem_do_ack),
		.done(mem_done),
		.load_data(load_data)
	);

endmodule

`default_nettype wire

// ==== dv/tb_memory_model.sv ====
`default_nettype none

module tb_memory_model (
	input  logic clk,
	input  logic reset,
	input  mips_pkg::mem_req_t req,
	output mips_pkg::word_t rdata,
	output logic ack
);

	mips_pkg::word_t mem [1024];
	logic busy;
	int delay;

	// every bit of the word address feeds the pattern.
	initial
	begin
		for (int i = 0; i < 1024; i++)
			mem[i] = (i * 32'h0101_0101 + 32'h1357_9bdf) ^ {i[9:0], 22'h2a_5a5a};
	end

	always @(posedge clk)
	begin
		if (reset)
		begin
			ack <= 1'b0;
			busy <= 1'b0;
			rdata <= '0;
			delay <= 0;
		end
		else if (ack)
		begin
			ack <= 1'b0; // the request drops on this edge.
			busy <= 1'b0;
		end
		else if (req.en && !busy)
		begin
			busy <= 1'b1;
			delay <= $urandom_range(3, 0);
		end
		else if (busy)
		begin
			if (delay == 0)
			begin
				ack <= 1'b1;
				rdata <= mem[req.addr];
				// bank 3 holds bits 31 to 24, the byte at offset 0.
				if (req.we)
				begin
					for (int b = 0; b < 4; b++)
						if (req.bank_select[b])
							mem[req.addr][8*b +: 8] <= req.di[8*b +: 8];
				end
			end
			else
				delay <= delay - 1;
		end
	end

endmodule

`default_nettype wire

// ==== dv/tb_instruction_decoder.sv ====
`default_nettype none

module tb_instruction_decoder;

	localparam int INSTR_COUNT = 128; // upper bound on the instructions issued.
	localparam int WATCHDOG_TIME = INSTR_COUNT * (8 + 3 + 4) * 10 * 2;

	logic clk;
	logic reset;
	logic data_in_ready;
	mips_pkg::word_t data_in;
	logic ack_prev;
	logic data_out_ready;
	mips_pkg::word_t data_out;
	logic ack_next;
	mips_pkg::mem_req_t mem_req;
	mips_pkg::word_t mem_do;
	logic mem_do_ack;

	mips_pkg::word_t ref_regs [32];
	mips_pkg::word_t mirror [1024];
	int errors = 0;
	int failed_tests = 0;
	int test_count = 0;
	int test_start_errors = 0;
	logic cur_load;
	logic [3:0] exp_banks;

	logic prev_ack_prev;
	logic prev_ready;
	logic prev_ack_next;
	logic prev_mem_ack;
	mips_pkg::word_t prev_data_out;
	mips_pkg::mem_req_t prev_req;

	instruction_decoder #(
		.MEM_ADDR_WIDTH(10)
	) u_dut (
		.clk(clk),
		.reset(reset),
		.data_in_ready(data_in_ready),
		.data_in(data_in),
		.ack_prev(ack_prev),
		.data_out_ready(data_out_ready),
		.data_out(data_out),
		.ack_next(ack_next),
		.mem_req(mem_req),
		.mem_do(mem_do),
		.mem_do_ack(mem_do_ack)
	);

	tb_memory_model u_mem (
		.clk(clk),
		.reset(reset),
		.req(mem_req),
		.rdata(mem_do),
		.ack(mem_do_ack)
	);

	always #5 clk = ~clk;

	initial
	begin
		#(WATCHDOG_TIME);
		$display("watchdog expired, the run did not finish in %0d time units", WATCHDOG_TIME);
		$display("Test failed");
		$finish;
	end

	task automatic flag_mismatch(input string sig, input mips_pkg::word_t exp,
		input mips_pkg::word_t got);
		$display("FAILED %s: expected %h, got %h", sig, exp, got);
		errors++;
	endtask

	task automatic flag_problem(input string msg);
		$display("error: %s", msg);
		errors++;
	endtask

	// ##################################################
	// handshake monitor that samples before the edge updates.
	// ##################################################

	always @(posedge clk)
	begin
		if (!reset)
		begin
			if (prev_ack_prev)
				assert (!ack_prev) else flag_problem("ack_prev lasted longer than one cycle");
			if (data_out_ready)
				assert (!ack_prev) else flag_problem("a strobe was acknowledged while busy");
			if (prev_ready && !prev_ack_next)
			begin
				assert (data_out_ready) else flag_problem("data_out_ready fell without ack_next");
				assert (data_out == prev_data_out)
					else flag_mismatch("data_out", prev_data_out, data_out);
			end
			if (prev_req.en && !prev_mem_ack)
				assert (mem_req == prev_req) else flag_problem("mem_req changed before mem_do_ack");
			if (prev_req.en && prev_mem_ack)
				assert (!mem_req.en) else flag_problem("mem_req.en stayed high after mem_do_ack");
			if (cur_load && mem_req.en)
				assert (!mem_req.we) else flag_problem("mem_req.we was high during a load");
			if (mem_req.en)
				assert (mem_req.bank_select == exp_banks)
					else flag_mismatch("mem_req.bank_select", 32'(exp_banks),
						32'(mem_req.bank_select));
		end
		prev_ack_prev <= ack_prev;
		prev_ready <= data_out_ready;
		prev_ack_next <= ack_next;
		prev_mem_ack <= mem_do_ack;
		prev_data_out <= data_out;
		prev_req <= mem_req;
	end

	// ##################################################
	// reference model.
	// ##################################################

	function automatic mips_pkg::word_t r_word(input logic [5:0] funct, input int rs,
		input int rt, input int rd, input logic [4:0] sa);
		return {mips_pkg::OPCODE_SPECIAL, 5'(rs), 5'(rt), 5'(rd), sa, funct};
	endfunction

	function automatic mips_pkg::word_t i_word(input logic [5:0] op, input int rs,
		input int rt, input logic [15:0] imm);
		return {op, 5'(rs), 5'(rt), imm};
	endfunction

	function automatic mips_pkg::word_t alu_ref(input logic [5:0] funct,
		input mips_pkg::word_t s, input mips_pkg::word_t t, input logic [4:0] sa);
		mips_pkg::word_t fill;
		fill = t[31] ? ~(32'hFFFF_FFFF >> sa) : 32'h0; // sign bits shifted in by sra.
		case (funct)
			mips_pkg::FUNCT_SLL: return t << sa;
			mips_pkg::FUNCT_SRL: return t >> sa;
			mips_pkg::FUNCT_SRA: return (t >> sa) | fill;
			mips_pkg::FUNCT_ADD, mips_pkg::FUNCT_ADDU: return s + t;
			mips_pkg::FUNCT_SUB, mips_pkg::FUNCT_SUBU: return s + ~t + 32'd1;
			mips_pkg::FUNCT_AND: return s & t;
			mips_pkg::FUNCT_OR: return s | t;
			mips_pkg::FUNCT_XOR: return s ^ t;
			mips_pkg::FUNCT_NOR: return ~s & ~t;
			mips_pkg::FUNCT_SLT: return (s[31] != t[31]) ? {31'd0, s[31]} : {31'd0, s < t};
			default: return '0;
		endcase
	endfunction

	// lanes are big-endian, so offset 0 is the top byte.
	function automatic mips_pkg::word_t load_ref(input logic [5:0] op, input logic [11:0] addr);
		mips_pkg::word_t w;
		logic [7:0] b;
		logic [15:0] h;
		int lane;
		w = mirror[addr[11:2]];
		lane = addr[1:0];
		b = w[31 - 8*lane -: 8];
		h = addr[1] ? w[15:0] : w[31:16];
		case (op)
			mips_pkg::OP_LB: return {{24{b[7]}}, b};
			mips_pkg::OP_LBU: return {24'd0, b};
			mips_pkg::OP_LH: return {{16{h[15]}}, h};
			mips_pkg::OP_LHU: return {16'd0, h};
			default: return w;
		endcase
	endfunction

	// bank 3 carries offset 0 and an access covers its aligned group of bytes.
	function automatic logic [3:0] banks_ref(input logic [5:0] op, input logic [1:0] offset);
		int size;
		int first;
		logic [3:0] banks;
		case (op)
			mips_pkg::OP_LW, mips_pkg::OP_SW: size = 4;
			mips_pkg::OP_LH, mips_pkg::OP_LHU, mips_pkg::OP_SH: size = 2;
			default: size = 1;
		endcase
		first = offset;
		first = first - (first % size);
		banks = '0;
		for (int j = 0; j < size; j++)
			banks[3 - first - j] = 1'b1;
		return banks;
	endfunction

	function automatic void store_ref(input logic [5:0] op, input logic [11:0] addr,
		input mips_pkg::word_t value);
		int lane;
		lane = addr[1:0];
		case (op)
			mips_pkg::OP_SB: mirror[addr[11:2]][31 - 8*lane -: 8] = value[7:0];
			mips_pkg::OP_SH:
			begin
				if (addr[1])
					mirror[addr[11:2]][15:0] = value[15:0];
				else
					mirror[addr[11:2]][31:16] = value[15:0];
			end
			default: mirror[addr[11:2]] = value;
		endcase
	endfunction

	// ##################################################
	// instruction sequencing.
	// ##################################################

	// called right after a rising edge, returns right after one with the DUT idle.
	task automatic run_instr(input mips_pkg::word_t w, input mips_pkg::word_t expected,
		input logic check_latency, input logic is_load);
		int waited;
		int hold;
		waited = 0;
		cur_load <= is_load;
		data_in_ready <= 1'b1;
		data_in <= w;
		@(posedge clk);
		while (!ack_prev)
			@(posedge clk);
		data_in_ready <= 1'b0;
		while (!data_out_ready)
		begin
			@(posedge clk);
			waited++;
		end
		if (check_latency)
			assert (waited == 3)
				else flag_problem($sformatf("data_out_ready rose after %0d cycles, not 3", waited));
		assert (data_out == expected) else flag_mismatch("data_out", expected, data_out);
		hold = $urandom_range(3, 0);
		repeat (hold)
		begin
			data_in_ready <= 1'($urandom_range(1, 0)); // strobes here must be ignored.
			data_in <= $urandom;
			@(posedge clk);
		end
		ack_next <= 1'b1;
		@(posedge clk);
		ack_next <= 1'b0;
		data_in_ready <= 1'b0;
		@(posedge clk);
		assert (!data_out_ready) else flag_problem("data_out_ready stayed high after ack_next");
		cur_load <= 1'b0;
	endtask

	task automatic do_load(input logic [5:0] op, input int rt, input int rs,
		input logic [15:0] imm);
		mips_pkg::word_t addr;
		mips_pkg::word_t expected;
		addr = ref_regs[rs] + {{16{imm[15]}}, imm};
		expected = load_ref(op, addr[11:0]);
		exp_banks <= banks_ref(op, addr[1:0]);
		run_instr(i_word(op, rs, rt, imm), expected, 1'b0, 1'b1);
		if (rt != 0)
			ref_regs[rt] = expected;
	endtask

	task automatic do_store(input logic [5:0] op, input int rt, input int rs,
		input logic [15:0] imm);
		mips_pkg::word_t addr;
		mips_pkg::word_t expected;
		addr = ref_regs[rs] + {{16{imm[15]}}, imm};
		expected = ref_regs[rt];
		exp_banks <= banks_ref(op, addr[1:0]);
		run_instr(i_word(op, rs, rt, imm), expected, 1'b0, 1'b0);
		store_ref(op, addr[11:0], expected);
		assert (u_mem.mem[addr[11:2]] == mirror[addr[11:2]])
			else flag_mismatch("memory word", mirror[addr[11:2]], u_mem.mem[addr[11:2]]);
	endtask

	task automatic do_rtype(input logic [5:0] funct, input int rd, input int rs, input int rt,
		input logic [4:0] sa);
		mips_pkg::word_t expected;
		expected = alu_ref(funct, ref_regs[rs], ref_regs[rt], sa);
		run_instr(r_word(funct, rs, rt, rd, sa), expected, 1'b1, 1'b0);
		if (rd != 0)
			ref_regs[rd] = expected;
	endtask

	task automatic end_test(input string name);
		test_count++;
		if (errors != test_start_errors)
			failed_tests++;
		$display("test %s finished with %0d errors", name, errors - test_start_errors);
		test_start_errors = errors;
	endtask

	initial
	begin
		int seed;
		logic [5:0] load_ops [5];
		int load_step [5];
		logic [5:0] store_ops [3];
		int store_step [3];
		logic [5:0] functs [12];
		int load_words [4];
		seed = $urandom(82289);
		clk = 1'b0;
		reset = 1'b1;
		data_in_ready = 1'b0;
		data_in = '0;
		ack_next = 1'b0;
		cur_load = 1'b0;
		for (int i = 0; i < 32; i++)
			ref_regs[i] = '0;
		load_ops = '{mips_pkg::OP_LW, mips_pkg::OP_LH, mips_pkg::OP_LHU, mips_pkg::OP_LB,
			mips_pkg::OP_LBU};
		load_step = '{4, 2, 2, 1, 1};
		store_ops = '{mips_pkg::OP_SW, mips_pkg::OP_SH, mips_pkg::OP_SB};
		store_step = '{4, 2, 1};
		functs = '{mips_pkg::FUNCT_SLL, mips_pkg::FUNCT_SRL, mips_pkg::FUNCT_SRA,
			mips_pkg::FUNCT_ADD, mips_pkg::FUNCT_ADDU, mips_pkg::FUNCT_SUB,
			mips_pkg::FUNCT_SUBU, mips_pkg::FUNCT_AND, mips_pkg::FUNCT_OR,
			mips_pkg::FUNCT_XOR, mips_pkg::FUNCT_NOR, mips_pkg::FUNCT_SLT};
		load_words = '{0, 5, 100, 1023};

		repeat (10) @(posedge clk);
		reset <= 1'b0;
		@(posedge clk);
		assert (!data_out_ready) else flag_problem("data_out_ready high after reset");
		assert (!ack_prev) else flag_problem("ack_prev high after reset");
		assert (!mem_req.en && !mem_req.we) else flag_problem("memory request active after reset");
		assert (data_out == '0) else flag_mismatch("data_out", '0, data_out);
		for (int i = 0; i < 1024; i++)
			mirror[i] = u_mem.mem[i];
		end_test("reset");

		for (int w = 0; w < 4; w++)
			for (int k = 0; k < 5; k++)
				for (int off = 0; off < 4; off += load_step[k])
					do_load(load_ops[k], 1 + $urandom_range(30, 0), 0, 16'(load_words[w]*4 + off));
		end_test("loads");

		// the operands are loaded first and every operation then runs twice.
		for (int i = 1; i <= 8; i++)
			do_load(mips_pkg::OP_LW, i, 0, 16'(800 + 4*i));
		for (int round = 0; round < 2; round++)
			for (int k = 0; k < 12; k++)
				do_rtype(functs[k], 9 + $urandom_range(14, 0), 1 + $urandom_range(22, 0),
					1 + $urandom_range(22, 0), 5'($urandom));
		end_test("rtype");

		for (int w = 40; w < 42; w++)
			for (int k = 0; k < 3; k++)
				for (int off = 0; off < 4; off += store_step[k])
				begin
					do_store(store_ops[k], 1 + $urandom_range(22, 0), 0, 16'(w*4 + off));
					do_load(mips_pkg::OP_LW, 24, 0, 16'(w*4));
				end
		end_test("stores");

		do_load(mips_pkg::OP_LW, 0, 0, 16'(300*4));
		do_rtype(mips_pkg::FUNCT_OR, 0, 1, 2, 5'd0);
		do_rtype(mips_pkg::FUNCT_ADDU, 25, 0, 5, 5'd0);
		do_rtype(mips_pkg::FUNCT_SUBU, 26, 5, 0, 5'd0);
		end_test("register_zero");

		// unsupported words give zero and the readbacks prove the targets kept their values.
		run_instr(i_word(6'h08, 1, 3, 16'h1234), '0, 1'b1, 1'b0);
		do_rtype(mips_pkg::FUNCT_ADDU, 27, 3, 0, 5'd0);
		run_instr(r_word(6'h3F, 1, 2, 4, 5'd0), '0, 1'b1, 1'b0);
		do_rtype(mips_pkg::FUNCT_ADDU, 28, 4, 0, 5'd0);
		end_test("unsupported");

		$display("%0d tests run, %0d failed, %0d errors", test_count, failed_tests, errors);
		if (errors == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== filelist.f ====
logic/mips_pkg.sv
logic/alu.sv
logic/register_file.sv
logic/load_store_unit.sv
logic/decode_fsm.sv
logic/instruction_decoder.sv
dv/tb_memory_model.sv
dv/tb_instruction_decoder.sv

// ==== Bender.yml ====
package:
  name: instruction_decoder

sources:
  - logic/mips_pkg.sv
  - logic/alu.sv
  - logic/register_file.sv
  - logic/load_store_unit.sv
  - logic/decode_fsm.sv
  - logic/instruction_decoder.sv
  - target: simulation
    files:
      - dv/tb_memory_model.sv
      - dv/tb_instruction_decoder.sv
